/* hdl/tile_gen_pkg.sv */
`default_nettype none

package tile_gen_pkg;

    // select codes as on a 74194 (s1, s0)
    typedef enum logic [1:0] {
        OP_HOLD  = 2'b00, // keep contents
        OP_SHR   = 2'b01, // toward bit 0
        OP_SHL   = 2'b10, // toward bit 7, msb out first
        OP_LOAD  = 2'b11  // parallel load
    } shift_op_e;

    // one 74161 slice
    localparam int STAGE_BITS = 4;

endpackage

`default_nettype wire

/* hdl/raster_if.sv */
`default_nettype none

interface raster_if #(
    parameter int WIDTH = 2 * tile_gen_pkg::STAGE_BITS
);
    import tile_gen_pkg::*;

    logic [WIDTH-1:0] hcount;   // horizontal position
    logic [WIDTH-1:0] vcount;   // line number
    logic             h_end;    // last clock of a line
    logic             v_end;    // last clock of a frame
    logic [7:0]       sx;       // scrolled column, pixels
    shift_op_e        shift_op; // shifter select
    logic             blank;    // outside the active area

    // both counters drive through this one
    modport counter (
        output hcount, vcount, h_end, v_end
    );

    modport adder (
        input  hcount, h_end,
        output sx
    );

    modport ctrl (
        input  hcount, vcount, h_end, v_end, sx,
        output shift_op, blank
    );

    modport shifter (
        input shift_op, blank
    );

endinterface

`default_nettype wire

/* hdl/sync_counter.sv */
`default_nettype none

module sync_counter #(
    parameter int               WIDTH     = 2 * tile_gen_pkg::STAGE_BITS,
    parameter logic [WIDTH-1:0] RESET_VAL = '0
) (
    input  logic             clk,
    input  logic             cl_b,
    input  logic             cet,
    input  logic             ld_b,
    input  logic [WIDTH-1:0] d,
    output logic [WIDTH-1:0] q,
    output logic             ca
);
    import tile_gen_pkg::*;

    localparam int NSTAGE = WIDTH / STAGE_BITS;

    // en_chain[i] enables stage i, the top entry is the ripple carry out
    logic [NSTAGE:0] en_chain;

    assign en_chain[0] = cet;

    for (genvar i = 0; i < NSTAGE; i++) begin : g_stage
        logic [STAGE_BITS-1:0] cnt; // one 4-bit slice

        always_ff @(posedge clk or negedge cl_b) begin
            if (!cl_b) begin
                cnt <= RESET_VAL[i*STAGE_BITS +: STAGE_BITS];
            end else if (!ld_b) begin
                cnt <= d[i*STAGE_BITS +: STAGE_BITS]; // load beats count
            end else if (en_chain[i]) begin
                cnt <= cnt + STAGE_BITS'(1);
            end
        end

        assign q[i*STAGE_BITS +: STAGE_BITS] = cnt;

        // lookahead to the next slice, like tc of a 74161
        assign en_chain[i+1] = en_chain[i] & (&cnt);
    end

    // all ones and enabled
    assign ca = en_chain[NSTAGE];

endmodule

`default_nettype wire

/* hdl/scroll_adder.sv */
`default_nettype none

module scroll_adder (
    input  logic       clk,
    input  logic       cl_b,
    input  logic [7:0] scroll,
    raster_if.adder    rif,
    output logic [4:0] fetch_col
);

    logic [7:0] scroll_q; // line-rate latch
    logic [7:0] hpos;
    logic [4:0] lo_sum;   // low slice with carry out
    logic [3:0] hi_sum;

    // new scroll takes effect at the start of the next line
    always_ff @(posedge clk or negedge cl_b) begin
        if (!cl_b) begin
            scroll_q <= 8'h00;
        end else if (rif.h_end) begin
            scroll_q <= scroll;
        end
    end

    assign hpos = rif.hcount[7:0];

    // two 283-style slices, carry out of the top one is dropped
    assign lo_sum = {1'b0, scroll_q[3:0]} + {1'b0, hpos[3:0]};
    assign hi_sum = scroll_q[7:4] + hpos[7:4] + {3'b000, lo_sum[4]};

    assign rif.sx = {hi_sum, lo_sum[3:0]};

    // the tile after the one on screen, wraps at 32
    assign fetch_col = rif.sx[7:3] + 5'd1;

endmodule

`default_nettype wire

/* hdl/pixel_shifter.sv */
`default_nettype none

module pixel_shifter (
    input  logic       clk,
    input  logic       cl_b,
    input  logic [7:0] tile_data,
    raster_if.shifter  rif,
    output logic       pixel
);
    import tile_gen_pkg::*;

    logic [7:0] sreg;

    // 8-bit version of the 74194
    always_ff @(posedge clk or negedge cl_b) begin
        if (!cl_b) begin
            sreg <= 8'h00;
        end else begin
            case (rif.shift_op)
                OP_SHR:  sreg <= {1'b0, sreg[7:1]};
                OP_SHL:  sreg <= {sreg[6:0], 1'b0};
                OP_LOAD: sreg <= tile_data;
                default: sreg <= sreg;              // hold
            endcase
        end
    end

    // serial out is the msb, dark while blanked
    assign pixel = sreg[7] & ~rif.blank;

endmodule

`default_nettype wire

/* hdl/timing_ctrl.sv */
`default_nettype none

module timing_ctrl #(
    parameter int H_LOAD = 192,
    parameter int V_LOAD = 240
) (
    input  logic clk,
    input  logic cl_b,
    raster_if.ctrl rif,
    output logic h_ld_b,
    output logic v_ld_b,
    output logic v_cet,
    output logic hsync,
    output logic vsync
);
    import tile_gen_pkg::*;

    // sync windows start at the preload, 8 clocks and 2 lines wide
    localparam logic [4:0] HS_TAG   = 5'(H_LOAD >> 3);
    localparam logic [6:0] VS_TAG   = 7'(V_LOAD >> 1);
    // first visible column and line
    localparam logic [7:0] H_ACTIVE = 8'(H_LOAD + 16);
    localparam logic [7:0] V_ACTIVE = 8'(V_LOAD + 4);

    logic       run;   // low only in the first cycle after reset
    logic [7:0] h_dec; // one-hot over hcount[5:3]
    logic [7:0] v_dec; // one-hot over vcount[3:1]

    always_ff @(posedge clk or negedge cl_b) begin
        if (!cl_b) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    // 138-style decoders, the upper bits act as the enables
    assign h_dec = (rif.hcount[7:6] == HS_TAG[4:3]) ? (8'b1 << rif.hcount[5:3]) : 8'h00;
    assign v_dec = (rif.vcount[7:4] == VS_TAG[6:3]) ? (8'b1 << rif.vcount[3:1]) : 8'h00;

    assign hsync = h_dec[HS_TAG[2:0]];
    assign vsync = v_dec[VS_TAG[2:0]];

    // left border and top border
    assign rif.blank = (rif.hcount[7:0] < H_ACTIVE) | (rif.vcount[7:0] < V_ACTIVE);

    // counters reload on their own carry
    assign h_ld_b = ~(rif.h_end & run);
    assign v_ld_b = ~(rif.v_end & run); // v_end already includes h_end
    assign v_cet  = rif.h_end;          // one line step per h carry

    // fetch the next byte on the last pixel of a tile
    assign rif.shift_op = (rif.sx[2:0] == 3'd7) ? OP_LOAD : OP_SHL;

endmodule

`default_nettype wire

/* hdl/tile_gen_top.sv */
`default_nettype none

module tile_gen_top #(
    parameter int H_LOAD = 192,
    parameter int V_LOAD = 240,
    parameter int WIDTH  = 2 * tile_gen_pkg::STAGE_BITS
) (
    input  logic       clk,
    input  logic       cl_b,
    input  logic [7:0] scroll,
    input  logic [7:0] tile_data,
    output logic [4:0] fetch_col,
    output logic [2:0] fetch_row,
    output logic       hsync,
    output logic       vsync,
    output logic       blank,
    output logic       pixel
);

    logic h_ld_b;
    logic v_ld_b;
    logic v_cet;

    raster_if #(.WIDTH(WIDTH)) rif ();

    // pixel counter, runs every clock
    sync_counter #(
        .WIDTH     (WIDTH),
        .RESET_VAL (WIDTH'(H_LOAD))
    ) u_hcnt (
        .clk  (clk),
        .cl_b (cl_b),
        .cet  (1'b1),
        .ld_b (h_ld_b),
        .d    (WIDTH'(H_LOAD)),
        .q    (rif.hcount),
        .ca   (rif.h_end)
    );

    // line counter, steps on the h carry
    sync_counter #(
        .WIDTH     (WIDTH),
        .RESET_VAL (WIDTH'(V_LOAD))
    ) u_vcnt (
        .clk  (clk),
        .cl_b (cl_b),
        .cet  (v_cet),
        .ld_b (v_ld_b),
        .d    (WIDTH'(V_LOAD)),
        .q    (rif.vcount),
        .ca   (rif.v_end)
    );

    scroll_adder u_scroll (
        .clk       (clk),
        .cl_b      (cl_b),
        .scroll    (scroll),
        .rif       (rif.adder),
        .fetch_col (fetch_col)
    );

    pixel_shifter u_shift (
        .clk       (clk),
        .cl_b      (cl_b),
        .tile_data (tile_data),
        .rif       (rif.shifter),
        .pixel     (pixel)
    );

    timing_ctrl #(
        .H_LOAD (H_LOAD),
        .V_LOAD (V_LOAD)
    ) u_ctrl (
        .clk    (clk),
        .cl_b   (cl_b),
        .rif    (rif.ctrl),
        .h_ld_b (h_ld_b),
        .v_ld_b (v_ld_b),
        .v_cet  (v_cet),
        .hsync  (hsync),
        .vsync  (vsync)
    );

    assign fetch_row = rif.vcount[2:0]; // row inside the 8-line tile
    assign blank     = rif.blank;

endmodule

`default_nettype wire

/* verification/tile_gen_properties.sv */
`default_nettype none

module tile_gen_properties #(
    parameter int H_LOAD = 192
) (
    input logic       clk,
    input logic       cl_b,
    input logic       hsync,
    input logic       blank,
    input logic       pixel,
    input logic       h_end,
    input logic [7:0] hcount,
    input logic [7:0] vcount
);

    localparam logic [7:0] H_ACTIVE = 8'd208; // first visible column
    localparam logic [7:0] V_ACTIVE = 8'd244; // first visible line

    logic [3:0] hs_len; // saturating count of hsync clocks

    always_ff @(posedge clk or negedge cl_b) begin
        if (!cl_b) begin
            hs_len <= 4'd0;
        end else if (!hsync) begin
            hs_len <= 4'd0;
        end else if (hs_len != 4'hf) begin
            hs_len <= hs_len + 4'd1;
        end
    end

    a_hsync_width: assert property (@(posedge clk) disable iff (!cl_b)
        hsync |-> (hs_len < 4'd8))
        else $error("hsync held longer than 8 clocks");

    // border taken from the counts and not from blank
    a_blank_dark: assert property (@(posedge clk) disable iff (!cl_b)
        ((hcount < H_ACTIVE) || (vcount < V_ACTIVE)) |-> (blank && !pixel))
        else $error("pixel high or blank low in the border");

    // line counter only moves on the h carry
    a_vcount_step: assert property (@(posedge clk) disable iff (!cl_b)
        !h_end |=> $stable(vcount))
        else $error("vcount changed without h_end");

    a_h_reload: assert property (@(posedge clk) disable iff (!cl_b)
        h_end |=> (hcount == 8'(H_LOAD)))
        else $error("hcount did not reload after h_end");

endmodule

`default_nettype wire

/* verification/tb_tile_gen.sv */
`default_nettype none

module tb_tile_gen;

    localparam logic [7:0] H_LOAD   = 8'd192;
    localparam logic [7:0] V_LOAD   = 8'd240;
    localparam logic [7:0] HS_END   = 8'd200; // first clock after hsync
    localparam logic [7:0] VS_END   = 8'd242;
    localparam logic [7:0] H_ACTIVE = 8'd208;
    localparam logic [7:0] V_ACTIVE = 8'd244;
    localparam int NUM_FRAMES = 8;
    localparam int TIMEOUT    = 64 * 16 * (NUM_FRAMES + 2);

    logic       clk;
    logic       cl_b;
    logic [7:0] scroll;
    logic [7:0] tile_data;
    logic [4:0] fetch_col;
    logic [2:0] fetch_row;
    logic       hsync;
    logic       vsync;
    logic       blank;
    logic       pixel;

    logic [7:0] m_h;      // model pixel count
    logic [7:0] m_v;      // model line count
    logic [7:0] m_scroll; // model scroll latch

    integer seed        = 75698;
    int     errors      = 0;
    int     checks      = 0;
    int     hs_run      = 0;
    int     vs_run      = 0;
    int     frames_seen = 0;
    logic   vs_prev     = 1'b0;
    logic   first_cycle = 1'b1;

    tile_gen_top #(
        .H_LOAD (int'(H_LOAD)),
        .V_LOAD (int'(V_LOAD)),
        .WIDTH  (8)
    ) u_dut (
        .clk       (clk),
        .cl_b      (cl_b),
        .scroll    (scroll),
        .tile_data (tile_data),
        .fetch_col (fetch_col),
        .fetch_row (fetch_row),
        .hsync     (hsync),
        .vsync     (vsync),
        .blank     (blank),
        .pixel     (pixel)
    );

    bind tile_gen_top tile_gen_properties #(.H_LOAD(H_LOAD)) u_props (
        .clk    (clk),
        .cl_b   (cl_b),
        .hsync  (hsync),
        .blank  (blank),
        .pixel  (pixel),
        .h_end  (rif.h_end),
        .hcount (rif.hcount),
        .vcount (rif.vcount)
    );

    // pattern rom, every address bit changes the byte
    function automatic logic [7:0] rom_byte(input logic [4:0] col, input logic [2:0] row);
        logic [7:0] addr;
        addr = {col, row};
        return (addr * 8'd37) ^ {addr[2:0], addr[7:3]} ^ 8'h96;
    endfunction

    function automatic logic is_blank(input logic [7:0] h, input logic [7:0] v);
        return (h < H_ACTIVE) || (v < V_ACTIVE);
    endfunction

    function automatic logic expected_pixel(input logic [7:0] h, input logic [7:0] v,
                                            input logic [7:0] sl);
        logic [7:0] sx;
        logic [7:0] pat;
        sx  = h + sl;
        pat = rom_byte(sx[7:3], v[2:0]);
        if (is_blank(h, v)) begin
            return 1'b0;
        end else begin
            return pat[3'd7 - sx[2:0]]; // msb is the left pixel
        end
    endfunction

    task automatic check(input string what, input logic [15:0] got, input logic [15:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("FAIL t=%0t %s: got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // raster model, same rules as the counters
    always @(posedge clk or negedge cl_b) begin
        if (!cl_b) begin
            m_h      <= H_LOAD;
            m_v      <= V_LOAD;
            m_scroll <= 8'h00;
        end else if (m_h == 8'hff) begin
            m_h      <= H_LOAD;
            m_scroll <= scroll;
            m_v      <= (m_v == 8'hff) ? V_LOAD : m_v + 8'd1;
        end else begin
            m_h <= m_h + 8'd1;
        end
    end

    // rom answers the fetch of the previous cycle
    always @(posedge clk) begin
        tile_data <= rom_byte(fetch_col, fetch_row);
        if (cl_b && vsync && frames_seen >= 3) begin
            scroll <= 8'($random(seed)); // first two frames stay at 0
        end
    end

    always @(negedge clk) begin : compare
        logic [7:0] sx;
        logic [4:0] col;
        if (cl_b) begin
            sx  = m_h + m_scroll;
            col = sx[7:3] + 5'd1;
            if (first_cycle) begin
                check("hsync after reset", 16'(hsync), 16'd1);
                check("vsync after reset", 16'(vsync), 16'd1);
                first_cycle = 1'b0;
            end
            check("hsync", 16'(hsync), 16'((m_h >= H_LOAD) && (m_h < HS_END)));
            check("vsync", 16'(vsync), 16'((m_v >= V_LOAD) && (m_v < VS_END)));
            check("blank", 16'(blank), 16'(is_blank(m_h, m_v)));
            check("fetch_col", 16'(fetch_col), 16'(col));
            check("fetch_row", 16'(fetch_row), 16'(m_v[2:0]));
            check("pixel", 16'(pixel), 16'(expected_pixel(m_h, m_v, m_scroll)));
            if (blank) begin
                check("pixel under blank", 16'(pixel), 16'd0);
            end
            if (hsync) begin
                hs_run = hs_run + 1;
            end else if (hs_run != 0) begin
                check("hsync width", 16'(hs_run), 16'd8);
                hs_run = 0;
            end
            if (vsync && !vs_prev) begin
                frames_seen = frames_seen + 1;
            end
            if (vsync) begin
                vs_run = vs_run + 1;
            end else if (vs_run != 0) begin
                check("vsync width", 16'(vs_run), 16'd128); // two lines
                vs_run = 0;
            end
            vs_prev = vsync;
        end
    end

    initial begin
        int cycles;
        cl_b      = 1'b0;
        scroll    = 8'h00;
        tile_data = 8'h00;
        cycles    = 0;
        repeat (8) @(posedge clk);
        cl_b <= 1'b1;
        while (frames_seen <= NUM_FRAMES && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        if (frames_seen <= NUM_FRAMES) begin
            $display("timeout: only %0d frames started in %0d clocks, checks %0d, errors %0d",
                     frames_seen, cycles, checks, errors);
            $display("*** FAILED ***");
        end else begin
            $display("checks %0d, errors %0d", checks, errors);
            if (errors == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
hdl/tile_gen_pkg.sv
hdl/raster_if.sv
hdl/sync_counter.sv
hdl/scroll_adder.sv
hdl/pixel_shifter.sv
hdl/timing_ctrl.sv
hdl/tile_gen_top.sv
verification/tile_gen_properties.sv
verification/tb_tile_gen.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_tile_gen
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= *** FAILED ***
PASS_MSG  ?= *** PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
